// ==== snow_cfg.svh ====
`ifndef SNOW_CFG_SVH
`define SNOW_CFG_SVH

// level layout in pixels, seven floor blocks followed by the step block
`define SNOW_BLOCK_NUM      8
`define SNOW_FLOOR_NUM      7
`define SNOW_BLOCK_W        25
`define SNOW_BLOCK_H        25
`define SNOW_FLOOR_Y        400
`define SNOW_STEP_X         175
`define SNOW_STEP_Y         375
`define SNOW_FIELD_W        200

// player sprite box and where it appears after restart
`define SNOW_PLAYER_W       47
`define SNOW_PLAYER_H       41
`define SNOW_SPAWN_X        0
`define SNOW_SPAWN_Y        300

// set 2 make codes of the keys in use
`define SNOW_KEY_JUMP       8'h1D
`define SNOW_KEY_LEFT       8'h1C
`define SNOW_KEY_RIGHT      8'h23
`define SNOW_KEY_RESTART    8'h2D

// clocks per movement tick
`define SNOW_TICK_DIV       4
// ticks between two horizontal pixels, minus one
`define SNOW_STEP_TICKS     75
// vertical periods in ticks per pixel
`define SNOW_RISE_START     25
`define SNOW_RISE_END       50
`define SNOW_FALL_START     50
`define SNOW_FALL_MIN       20
`define SNOW_SPEED_STEP     5
`define SNOW_SPEED_PIXELS   24

`endif

// ==== snow_pkg.sv ====
`include "snow_cfg.svh"

package snow_pkg;

    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;
    typedef logic [7:0] scan_code_t;
    typedef logic [`SNOW_BLOCK_NUM-1:0] ice_mask_t;

    // bit 8 marks a release, as the scan-code framer delivers it
    typedef struct packed {
        logic       brk;
        scan_code_t code;
    } key_evt_t;

    typedef struct packed {
        logic jump;
        logic left;
        logic right;
    } keys_t;

    // contact flags as seen from the player box
    typedef struct packed {
        logic below;
        logic above;
        logic right_side;
        logic left_side;
    } sides_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } pos_t;

    typedef enum logic [1:0] {
        GAME_IDLE = 2'b00,
        GAME_PLAY = 2'b01,
        GAME_WIN  = 2'b11
    } game_state_e;

    typedef enum logic [1:0] {
        AIR_GROUND = 2'b00,
        AIR_RISE   = 2'b01,
        AIR_FALL   = 2'b10
    } air_phase_e;

endpackage

// ==== key_decoder.sv ====
`timescale 1ns/1ps
`include "snow_cfg.svh"

module key_decoder (
    input  logic               clk,
    input  logic               rst_n_i,
    input  snow_pkg::key_evt_t key_evt_i,
    input  logic               key_valid_i,
    output snow_pkg::keys_t    keys_o,
    output logic               restart_o,
    output logic               move_press_o
);

    logic hit_jump;
    logic hit_left;
    logic hit_right;
    logic hit_restart;
    logic is_make;

    assign hit_jump    = key_valid_i && (key_evt_i.code == `SNOW_KEY_JUMP);
    assign hit_left    = key_valid_i && (key_evt_i.code == `SNOW_KEY_LEFT);
    assign hit_right   = key_valid_i && (key_evt_i.code == `SNOW_KEY_RIGHT);
    assign hit_restart = key_valid_i && (key_evt_i.code == `SNOW_KEY_RESTART);
    assign is_make     = !key_evt_i.brk;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            keys_o       <= '0;
            restart_o    <= 1'b0;
            move_press_o <= 1'b0;
        end else begin
            restart_o    <= hit_restart && is_make;
            move_press_o <= (hit_jump || hit_left || hit_right) && is_make;
            // make holds the key, break drops only the key it names
            if (hit_jump) begin
                keys_o.jump <= is_make;
            end
            if (hit_left) begin
                keys_o.left <= is_make;
            end
            if (hit_right) begin
                keys_o.right <= is_make;
            end
        end
    end

endmodule

// ==== block_probe.sv ====
`timescale 1ns/1ps
`include "snow_cfg.svh"

module block_probe (
    input  logic             clk,
    input  logic             rst_n_i,
    input  snow_pkg::pos_t   pos_i,
    input  snow_pkg::pos_t   block_i,
    input  logic             ice_en_i,
    input  logic             clear_i,
    output snow_pkg::sides_t sides_o,
    output logic             iced_o
);

    // edges carry one extra bit so the far edge never wraps
    logic [10:0] px_lo;
    logic [10:0] px_hi;
    logic [10:0] bx_lo;
    logic [10:0] bx_hi;
    logic [9:0]  py_lo;
    logic [9:0]  py_hi;
    logic [9:0]  by_lo;
    logic [9:0]  by_hi;
    logic        h_overlap;
    logic        v_overlap;

    // hi edges are exclusive, one past the last pixel of the box
    assign px_lo = {1'b0, pos_i.x};
    assign px_hi = px_lo + 11'(`SNOW_PLAYER_W);
    assign bx_lo = {1'b0, block_i.x};
    assign bx_hi = bx_lo + 11'(`SNOW_BLOCK_W);
    assign py_lo = {1'b0, pos_i.y};
    assign py_hi = py_lo + 10'(`SNOW_PLAYER_H);
    assign by_lo = {1'b0, block_i.y};
    assign by_hi = by_lo + 10'(`SNOW_BLOCK_H);

    assign h_overlap = (px_lo < bx_hi) && (px_hi > bx_lo);
    assign v_overlap = (py_lo < by_hi) && (py_hi > by_lo);

    // feet on the block top, head at its bottom, or an edge pressed against a side
    assign sides_o.below      = h_overlap && (py_hi == by_lo);
    assign sides_o.above      = h_overlap && (py_lo == by_hi);
    assign sides_o.right_side = v_overlap && (px_hi == bx_lo);
    assign sides_o.left_side  = v_overlap && (px_lo == bx_hi);

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            iced_o <= 1'b0;
        end else if (ice_en_i && sides_o.below) begin
            iced_o <= 1'b1;
        end
    end

endmodule

// ==== block_field.sv ====
`timescale 1ns/1ps
`include "snow_cfg.svh"

module block_field (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  snow_pkg::pos_t        pos_i,
    input  snow_pkg::game_state_e state_i,
    input  logic                  restart_i,
    output snow_pkg::sides_t      sides_o,
    output snow_pkg::ice_mask_t   ice_o
);

    snow_pkg::pos_t   blk_pos   [`SNOW_BLOCK_NUM];
    snow_pkg::sides_t blk_sides [`SNOW_BLOCK_NUM];
    snow_pkg::sides_t sides_any;
    logic             ice_en;

    // blocks only turn to ice while a game is running
    assign ice_en = (state_i == snow_pkg::GAME_PLAY);

    for (genvar i = 0; i < `SNOW_BLOCK_NUM; i++) begin : g_block
        if (i < `SNOW_FLOOR_NUM) begin : g_floor
            assign blk_pos[i].x = snow_pkg::coord_x_t'(i * `SNOW_BLOCK_W);
            assign blk_pos[i].y = snow_pkg::coord_y_t'(`SNOW_FLOOR_Y);
        end else begin : g_step
            assign blk_pos[i].x = snow_pkg::coord_x_t'(`SNOW_STEP_X);
            assign blk_pos[i].y = snow_pkg::coord_y_t'(`SNOW_STEP_Y);
        end

        block_probe u_probe (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .pos_i    (pos_i),
            .block_i  (blk_pos[i]),
            .ice_en_i (ice_en),
            .clear_i  (restart_i),
            .sides_o  (blk_sides[i]),
            .iced_o   (ice_o[i])
        );
    end

    always_comb begin
        sides_any = '0;
        for (int i = 0; i < `SNOW_BLOCK_NUM; i++) begin
            sides_any = sides_any | blk_sides[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sides_o <= '0;
        end else begin
            sides_o <= sides_any;
        end
    end

endmodule

// ==== player_motion.sv ====
`timescale 1ns/1ps
`include "snow_cfg.svh"

module player_motion (
    input  logic             clk,
    input  logic             rst_n_i,
    input  snow_pkg::keys_t  keys_i,
    input  snow_pkg::sides_t sides_i,
    input  logic             restart_i,
    output snow_pkg::pos_t   pos_o
);

    logic [3:0]             tick_cnt;
    logic                   tick;
    logic [6:0]             step_cnt;
    logic [5:0]             rise_cnt;
    logic [5:0]             rise_per;
    logic [4:0]             rise_pix;
    logic [5:0]             fall_cnt;
    logic [5:0]             fall_per;
    logic [4:0]             fall_pix;
    snow_pkg::air_phase_e   phase;
    snow_pkg::coord_x_t     x_q;
    snow_pkg::coord_y_t     y_q;
    logic                   go_left;
    logic                   go_right;
    logic                   rise_done;

    assign pos_o.x = x_q;
    assign pos_o.y = y_q;

    assign tick = (tick_cnt == 4'(`SNOW_TICK_DIV - 1));

    // left has priority when both keys are held
    assign go_left  = keys_i.left && !sides_i.left_side && (x_q != '0);
    assign go_right = keys_i.right && !keys_i.left && !sides_i.right_side
                   && (x_q < snow_pkg::coord_x_t'(`SNOW_FIELD_W - `SNOW_PLAYER_W));

    // head bump or rise slowed down to its end period
    assign rise_done = sides_i.above || (rise_per >= 6'(`SNOW_RISE_END));

    always_ff @(posedge clk) begin
        if (!rst_n_i || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 4'd1;
        end
    end

    // horizontal stepping, counter restarts whenever the move is blocked
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            x_q      <= snow_pkg::coord_x_t'(`SNOW_SPAWN_X);
            step_cnt <= '0;
        end else if (tick) begin
            if (go_left || go_right) begin
                if (step_cnt < 7'(`SNOW_STEP_TICKS)) begin
                    step_cnt <= step_cnt + 7'd1;
                end else begin
                    step_cnt <= '0;
                    x_q      <= go_left ? x_q - 10'd1 : x_q + 10'd1;
                end
            end else begin
                step_cnt <= '0;
            end
        end
    end

    // vertical phases, each pixel waits for its period counter
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            y_q      <= snow_pkg::coord_y_t'(`SNOW_SPAWN_Y);
            phase    <= snow_pkg::AIR_GROUND;
            rise_cnt <= '0;
            rise_per <= 6'(`SNOW_RISE_START);
            rise_pix <= '0;
            fall_cnt <= '0;
            fall_per <= 6'(`SNOW_FALL_START);
            fall_pix <= '0;
        end else if (tick) begin
            case (phase)
                snow_pkg::AIR_GROUND: begin
                    if (sides_i.below && keys_i.jump) begin
                        phase <= snow_pkg::AIR_RISE;
                    end else if (!sides_i.below) begin
                        phase <= snow_pkg::AIR_FALL;
                    end
                end
                snow_pkg::AIR_RISE: begin
                    if (rise_done) begin
                        phase    <= snow_pkg::AIR_FALL;
                        rise_cnt <= '0;
                        rise_per <= 6'(`SNOW_RISE_START);
                        rise_pix <= '0;
                    end else if (rise_cnt < rise_per) begin
                        rise_cnt <= rise_cnt + 6'd1;
                    end else begin
                        rise_cnt <= '0;
                        y_q      <= y_q - 9'd1;
                        // rising gets slower every few pixels
                        if (rise_pix == 5'(`SNOW_SPEED_PIXELS - 1)) begin
                            rise_pix <= '0;
                            rise_per <= rise_per + 6'(`SNOW_SPEED_STEP);
                        end else begin
                            rise_pix <= rise_pix + 5'd1;
                        end
                    end
                end
                snow_pkg::AIR_FALL: begin
                    if (sides_i.below) begin
                        phase    <= snow_pkg::AIR_GROUND;
                        fall_cnt <= '0;
                        fall_per <= 6'(`SNOW_FALL_START);
                        fall_pix <= '0;
                    end else if (fall_cnt < fall_per) begin
                        fall_cnt <= fall_cnt + 6'd1;
                    end else begin
                        fall_cnt <= '0;
                        y_q      <= y_q + 9'd1;
                        // falling speeds up until the minimum period
                        if (fall_pix == 5'(`SNOW_SPEED_PIXELS - 1)) begin
                            fall_pix <= '0;
                            if (fall_per >= 6'(`SNOW_FALL_MIN + `SNOW_SPEED_STEP)) begin
                                fall_per <= fall_per - 6'(`SNOW_SPEED_STEP);
                            end else begin
                                fall_per <= 6'(`SNOW_FALL_MIN);
                            end
                        end else begin
                            fall_pix <= fall_pix + 5'd1;
                        end
                    end
                end
                default: begin
                    phase <= snow_pkg::AIR_GROUND;
                end
            endcase
        end
    end

endmodule

// ==== game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  move_press_i,
    input  snow_pkg::ice_mask_t   ice_i,
    input  logic                  restart_i,
    output snow_pkg::game_state_e state_o
);

    snow_pkg::game_state_e state_d;

    always_comb begin
        state_d = state_o;
        case (state_o)
            snow_pkg::GAME_IDLE: begin
                if (move_press_i) begin
                    state_d = snow_pkg::GAME_PLAY;
                end
            end
            snow_pkg::GAME_PLAY: begin
                // every block iced ends the level
                if (ice_i == '1) begin
                    state_d = snow_pkg::GAME_WIN;
                end
            end
            default: begin
                state_d = state_o;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            state_o <= snow_pkg::GAME_IDLE;
        end else begin
            state_o <= state_d;
        end
    end

endmodule

// ==== snow_top.sv ====
`timescale 1ns/1ps

module snow_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  snow_pkg::key_evt_t    key_evt_i,
    input  logic                  key_valid_i,
    output snow_pkg::pos_t        pos_o,
    output snow_pkg::ice_mask_t   ice_o,
    output snow_pkg::game_state_e state_o
);

    snow_pkg::keys_t  keys;
    snow_pkg::sides_t sides;
    logic             restart;
    logic             move_press;

    key_decoder u_keys (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .key_evt_i    (key_evt_i),
        .key_valid_i  (key_valid_i),
        .keys_o       (keys),
        .restart_o    (restart),
        .move_press_o (move_press)
    );

    // position feeds the block field, contacts come back one cycle later
    player_motion u_motion (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .keys_i    (keys),
        .sides_i   (sides),
        .restart_i (restart),
        .pos_o     (pos_o)
    );

    block_field u_field (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pos_i     (pos_o),
        .state_i   (state_o),
        .restart_i (restart),
        .sides_o   (sides),
        .ice_o     (ice_o)
    );

    game_fsm u_game (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .move_press_i (move_press),
        .ice_i        (ice_o),
        .restart_i    (restart),
        .state_o      (state_o)
    );

endmodule

// ==== snow_chk.sv ====
`timescale 1ns/1ps
`include "snow_cfg.svh"

module snow_chk (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  restart_i,
    input snow_pkg::pos_t        pos_i,
    input snow_pkg::ice_mask_t   ice_i,
    input snow_pkg::game_state_e state_i
);

    // number of failed assertions so far
    int fail_cnt = 0;

    // win is left only through restart
    a_win_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_i == snow_pkg::GAME_WIN && !restart_i) |=> (state_i == snow_pkg::GAME_WIN))
        else begin
            fail_cnt++;
            $error("state left WIN without restart");
        end

    // ice bits only drop on restart
    a_ice_keep: assert property (@(posedge clk) disable iff (!rst_n_i)
        !restart_i |=> ((ice_i & $past(ice_i)) == $past(ice_i)))
        else begin
            fail_cnt++;
            $error("ice mask lost a bit without restart");
        end

    a_x_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        pos_i.x <= snow_pkg::coord_x_t'(`SNOW_FIELD_W - `SNOW_PLAYER_W))
        else begin
            fail_cnt++;
            $error("player x outside the field");
        end

endmodule

bind snow_top snow_chk u_chk (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .restart_i (restart),
    .pos_i     (pos_o),
    .ice_i     (ice_o),
    .state_i   (state_o)
);

// ==== tb_snow.sv ====
`timescale 1ns/1ps
`include "snow_cfg.svh"

module tb_snow;

    localparam int ROWS       = 11;
    localparam int WAIT_LIMIT = 12000;
    localparam int SETTLE     = 2;

    typedef struct packed {
        logic [1:0]            n_evt;
        snow_pkg::key_evt_t    evt0;
        snow_pkg::key_evt_t    evt1;
        logic [15:0]           hold;
        logic                  x_care;
        snow_pkg::coord_x_t    x;
        logic                  y_max;
        snow_pkg::coord_y_t    y;
        snow_pkg::ice_mask_t   ice;
        snow_pkg::game_state_e state;
    } step_t;

    logic                  clk;
    logic                  rst_n_i;
    snow_pkg::key_evt_t    key_evt_i;
    logic                  key_valid_i;
    snow_pkg::pos_t        pos_o;
    snow_pkg::ice_mask_t   ice_o;
    snow_pkg::game_state_e state_o;

    step_t table_q [ROWS];

    snow_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .key_evt_i   (key_evt_i),
        .key_valid_i (key_valid_i),
        .pos_o       (pos_o),
        .ice_o       (ice_o),
        .state_o     (state_o)
    );

    always #4 clk = ~clk;

    function automatic snow_pkg::key_evt_t evt(input logic brk, input logic [7:0] code);
        snow_pkg::key_evt_t e;
        e.brk  = brk;
        e.code = code;
        return e;
    endfunction

    function automatic step_t make_row(input int n, input snow_pkg::key_evt_t e0,
                                       input snow_pkg::key_evt_t e1, input int hold,
                                       input logic xc, input int x, input logic ym,
                                       input int y, input logic [7:0] ice,
                                       input snow_pkg::game_state_e st);
        step_t r;
        r.n_evt  = 2'(n);
        r.evt0   = e0;
        r.evt1   = e1;
        r.hold   = 16'(hold);
        r.x_care = xc;
        r.x      = snow_pkg::coord_x_t'(x);
        r.y_max  = ym;
        r.y      = snow_pkg::coord_y_t'(y);
        r.ice    = ice;
        r.state  = st;
        return r;
    endfunction

    task automatic fill_table();
        snow_pkg::key_evt_t none;
        none = '0;
        // spawn, then fall onto the floor
        table_q[0]  = make_row(0, none, none, 0, 1, 0, 0, 300, 8'h00, snow_pkg::GAME_IDLE);
        table_q[1]  = make_row(0, none, none, 3200, 1, 0, 0, 359, 8'h00, snow_pkg::GAME_IDLE);
        // walk right ten pixels, back left five
        table_q[2]  = make_row(1, evt(0, `SNOW_KEY_RIGHT), none, 760, 1, 10, 0, 359,
                               8'h07, snow_pkg::GAME_PLAY);
        table_q[3]  = make_row(2, evt(1, `SNOW_KEY_RIGHT), evt(0, `SNOW_KEY_LEFT), 380,
                               1, 5, 0, 359, 8'h07, snow_pkg::GAME_PLAY);
        // run into the step
        table_q[4]  = make_row(2, evt(1, `SNOW_KEY_LEFT), evt(0, `SNOW_KEY_RIGHT), 9600,
                               1, 128, 0, 359, 8'h7F, snow_pkg::GAME_PLAY);
        // plain jump and landing
        table_q[5]  = make_row(2, evt(1, `SNOW_KEY_RIGHT), evt(0, `SNOW_KEY_JUMP), 100,
                               1, 128, 1, 358, 8'h7F, snow_pkg::GAME_PLAY);
        table_q[6]  = make_row(1, evt(1, `SNOW_KEY_JUMP), none, 0, 1, 128, 0, 359,
                               8'h7F, snow_pkg::GAME_PLAY);
        // jump onto the step
        table_q[7]  = make_row(2, evt(0, `SNOW_KEY_JUMP), evt(0, `SNOW_KEY_RIGHT), 200,
                               0, 0, 1, 355, 8'h7F, snow_pkg::GAME_PLAY);
        table_q[8]  = make_row(1, evt(1, `SNOW_KEY_JUMP), none, 9000, 0, 0, 0, 334,
                               8'hFF, snow_pkg::GAME_WIN);
        table_q[9]  = make_row(1, evt(1, `SNOW_KEY_RIGHT), none, 500, 0, 0, 0, 334,
                               8'hFF, snow_pkg::GAME_WIN);
        table_q[10] = make_row(1, evt(0, `SNOW_KEY_RESTART), none, 2, 1, 0, 0, 300,
                               8'h00, snow_pkg::GAME_IDLE);
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_evt(input snow_pkg::key_evt_t e);
        key_evt_i   = e;
        key_valid_i = 1'b1;
        @(negedge clk);
        key_valid_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_ticks(input int n);
        repeat (n * `SNOW_TICK_DIV) @(negedge clk);
    endtask

    function automatic logic pos_ok(input step_t r);
        logic x_ok;
        logic y_ok;
        x_ok = !r.x_care || (pos_o.x == r.x);
        y_ok = r.y_max ? (pos_o.y <= r.y) : (pos_o.y == r.y);
        return x_ok && y_ok;
    endfunction

    task automatic run_row(input step_t r);
        int n;
        if (r.n_evt > 0) send_evt(r.evt0);
        if (r.n_evt > 1) send_evt(r.evt1);
        wait_ticks(int'(r.hold));
        n = 0;
        while (!pos_ok(r) && n < WAIT_LIMIT) begin
            wait_ticks(1);
            n++;
        end
        // contacts, ice and state trail the position by a few cycles
        wait_ticks(SETTLE);
        if (r.x_care) check("x", 32'(pos_o.x), 32'(r.x));
        if (r.y_max) begin
            check("y at most", 32'(pos_o.y <= r.y), 32'd1);
        end else begin
            check("y", 32'(pos_o.y), 32'(r.y));
        end
        check("ice", 32'(ice_o), 32'(r.ice));
        check("state", 32'(state_o), 32'(r.state));
    endtask

    // watchdog sized from the table
    initial begin
        longint total;
        #1;
        total = 0;
        for (int i = 0; i < ROWS; i++) begin
            total += longint'(table_q[i].hold) + SETTLE + WAIT_LIMIT + 4;
        end
        total = total * `SNOW_TICK_DIV * 8 + 10000;
        #(total);
        $display("timeout: the test did not finish in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        key_evt_i   = '0;
        key_valid_i = 1'b0;
        fill_table();
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            run_row(table_q[i]);
        end
        // the bound checker counts its failed assertions
        if (u_dut.u_chk.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
snow_pkg.sv
key_decoder.sv
block_probe.sv
block_field.sv
player_motion.sv
game_fsm.sv
snow_top.sv
snow_chk.sv
tb_snow.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the snow game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_snow -o sim_snow
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_snow)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "No errors"; then
    exit 0
fi
echo "pass message not found"
exit 1
